/* mips_backend.f */
mips_ctrl_pkg.sv
mips_data_pkg.sv
ex_mem_if.sv
execute_stage.sv
ex_mem_reg.sv
mem_access.sv
mem_wb_reg.sv
mips_backend.sv
tb_wb_memory.sv
tb_mips_backend.sv

/* tb_mips_backend.sv */
module tb_mips_backend
    import mips_ctrl_pkg::*, mips_data_pkg::*;
();

    logic         i_clock;
    logic         reset;
    logic         issue_valid;
    alu_op_t      alu_op;
    logic         alu_src;
    word_t        operand_a;
    word_t        operand_b;
    word_t        imm;
    word_t        pc;
    logic [4:0]   shamt;
    logic         reg_write;
    logic         mem_to_reg;
    logic         mem_read;
    logic         mem_write;
    logic         branch;
    logic         load_unsigned;
    logic         r31_ctrl;
    reg_idx_t     dest_reg;
    access_size_t size;
    logic         issue_ready;
    logic         branch_taken;
    word_t        branch_target;
    logic         wb_valid;
    logic         wb_we;
    reg_idx_t     wb_reg;
    word_t        wb_data;
    logic         wb_cyc;
    logic         wb_stb;
    logic         wb_write;
    word_t        wb_adr;
    logic [3:0]   wb_sel;
    word_t        wb_dat_w;
    word_t        wb_dat_r;
    logic         wb_ack;

    int           cycle_count;
    logic         exp_we[$];
    reg_idx_t     exp_reg[$];
    word_t        exp_data[$];

    mips_backend mips_backend_i (.*);

    tb_wb_memory memory_i (
        .i_clock (i_clock),
        .reset   (reset),
        .cyc     (wb_cyc),
        .stb     (wb_stb),
        .we      (wb_write),
        .adr     (wb_adr),
        .sel     (wb_sel),
        .dat_w   (wb_dat_w),
        .dat_r   (wb_dat_r),
        .ack     (wb_ack)
    );

    initial begin
        i_clock = 1'b0;
        forever #2 i_clock = ~i_clock;
    end

    // ########################################
    // Checking helpers
    // ########################################

    task automatic stop_on_error();
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        assert (got === exp) else begin
            $display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        assert (got === exp) else begin
            $display("error at %0t: %s is %b, expected %b", $time, name, got, exp);
            stop_on_error();
        end
    endtask

    always @(posedge i_clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= 2000) begin
            $display("Run stopped: cycle limit reached before tests finished");
            $display("Verification failed");
            $fatal(1);
        end
    end

    // Retire monitor, in issue order.
    always @(negedge i_clock) begin
        if (!reset && wb_valid) begin
            assert (exp_we.size() > 0) else begin
                $display("A write-back retired with no instruction outstanding");
                stop_on_error();
            end
            check_bit("wb_we", wb_we, exp_we[0]);
            if (exp_we[0]) begin
                check_word("wb_reg", word_t'(wb_reg), word_t'(exp_reg[0]));
                check_word("wb_data", wb_data, exp_data[0]);
            end
            void'(exp_we.pop_front());
            void'(exp_reg.pop_front());
            void'(exp_data.pop_front());
        end
    end

    // ########################################
    // Issue helpers
    // ########################################

    task automatic expect_retire(input logic we, input reg_idx_t r, input word_t d);
        exp_we.push_back(we);
        exp_reg.push_back(r);
        exp_data.push_back(d);
    endtask

    // Inputs are held until EX/MEM takes them.
    task automatic issue_op(input alu_op_t op, input logic src, input word_t a,
                            input word_t b, input word_t im, input word_t p,
                            input logic [4:0] sh, input logic rw, input logic rd,
                            input logic wr, input logic br, input logic uns,
                            input logic link, input reg_idx_t dst,
                            input access_size_t sz);
        @(posedge i_clock);
        issue_valid   <= 1'b1;
        alu_op        <= op;
        alu_src       <= src;
        operand_a     <= a;
        operand_b     <= b;
        imm           <= im;
        pc            <= p;
        shamt         <= sh;
        reg_write     <= rw;
        mem_to_reg    <= rd;
        mem_read      <= rd;
        mem_write     <= wr;
        branch        <= br;
        load_unsigned <= uns;
        r31_ctrl      <= link;
        dest_reg      <= dst;
        size          <= sz;
        do begin
            @(negedge i_clock);
        end while (!issue_ready);
    endtask

    task automatic go_idle();
        @(posedge i_clock);
        issue_valid <= 1'b0;
    endtask

    task automatic run_alu(input alu_op_t op, input logic src, input word_t a,
                           input word_t b, input word_t im, input logic [4:0] sh,
                           input reg_idx_t dst, input word_t exp);
        expect_retire(dst != 0, dst, exp);
        issue_op(op, src, a, b, im, 32'h0, sh, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0,
                 1'b0, dst, SIZE_WORD);
        go_idle();
        @(negedge i_clock);
        check_bit("wb_valid one cycle after issue", wb_valid, 1'b1);
    endtask

    task automatic run_branch(input word_t a, input word_t b, input word_t im,
                              input word_t p, input logic exp_taken,
                              input word_t exp_target);
        expect_retire(1'b0, 5'd0, 32'h0);
        issue_op(ALU_SUB, 1'b0, a, b, im, p, 5'd0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0,
                 1'b0, 5'd0, SIZE_WORD);
        @(posedge i_clock);
        issue_valid <= 1'b0;
        check_bit("branch_taken", branch_taken, exp_taken);
        check_word("branch_target", branch_target, exp_target);
    endtask

    task automatic wait_mem_done();
        do begin
            @(posedge i_clock);
            issue_valid <= 1'b0;
            #1;
            if (!wb_valid) begin
                check_bit("issue_ready while waiting", issue_ready, 1'b0);
                check_bit("wb_cyc while waiting", wb_cyc, 1'b1);
            end
        end while (!wb_valid);
        check_bit("issue_ready after ack", issue_ready, 1'b1);
    endtask

    task automatic run_store(input access_size_t sz, input word_t addr, input word_t d,
                             input logic [3:0] exp_sel, input word_t exp_dat);
        expect_retire(1'b0, 5'd0, 32'h0);
        issue_op(ALU_ADD, 1'b1, addr, d, 32'h0, 32'h0, 5'd0, 1'b0, 1'b0, 1'b1,
                 1'b0, 1'b0, 1'b0, 5'd0, sz);
        #1;
        check_bit("wb_write", wb_write, 1'b1);
        check_word("wb_sel", word_t'(wb_sel), word_t'(exp_sel));
        check_word("wb_adr", wb_adr, {addr[31:2], 2'b00});
        check_word("wb_dat_w", wb_dat_w, exp_dat);
        wait_mem_done();
    endtask

    task automatic run_load(input access_size_t sz, input logic uns, input word_t addr,
                            input logic [3:0] exp_sel, input reg_idx_t dst,
                            input word_t exp);
        expect_retire(1'b1, dst, exp);
        issue_op(ALU_ADD, 1'b1, addr, 32'h0, 32'h0, 32'h0, 5'd0, 1'b1, 1'b1, 1'b0,
                 1'b0, uns, 1'b0, dst, sz);
        #1;
        check_bit("wb_write", wb_write, 1'b0);
        check_word("wb_sel", word_t'(wb_sel), word_t'(exp_sel));
        wait_mem_done();
    endtask

    // ########################################
    // Test sequence
    // ########################################

    initial begin
        cycle_count   = 0;
        reset         = 1'b1;
        issue_valid   = 1'b0;
        alu_op        = ALU_ADD;
        alu_src       = 1'b0;
        operand_a     = '0;
        operand_b     = '0;
        imm           = '0;
        pc            = '0;
        shamt         = '0;
        reg_write     = 1'b0;
        mem_to_reg    = 1'b0;
        mem_read      = 1'b0;
        mem_write     = 1'b0;
        branch        = 1'b0;
        load_unsigned = 1'b0;
        r31_ctrl      = 1'b0;
        dest_reg      = '0;
        size          = SIZE_WORD;
        repeat (16) @(posedge i_clock);
        reset <= 1'b0;
        @(negedge i_clock);

        // State after reset.
        check_bit("wb_valid", wb_valid, 1'b0);
        check_bit("wb_cyc", wb_cyc, 1'b0);
        check_bit("wb_stb", wb_stb, 1'b0);
        check_bit("branch_taken", branch_taken, 1'b0);
        check_bit("issue_ready", issue_ready, 1'b1);

        run_alu(ALU_ADD, 1'b0, 32'd5, 32'd7, 32'h0, 5'd0, 5'd3, 32'd12);
        run_alu(ALU_SUB, 1'b0, 32'd3, 32'd5, 32'h0, 5'd0, 5'd4, 32'hffff_fffe);
        run_alu(ALU_SLT, 1'b0, 32'hffff_ffff, 32'd1, 32'h0, 5'd0, 5'd5, 32'd1);
        run_alu(ALU_SLTU, 1'b0, 32'hffff_ffff, 32'd1, 32'h0, 5'd0, 5'd6, 32'd0);
        run_alu(ALU_SLL, 1'b0, 32'h0, 32'd1, 32'h0, 5'd4, 5'd7, 32'd16);
        run_alu(ALU_SRA, 1'b0, 32'h0, 32'h8000_0000, 32'h0, 5'd4, 5'd8, 32'hf800_0000);
        run_alu(ALU_LUI, 1'b1, 32'h0, 32'h0, 32'h1234, 5'd0, 5'd9, 32'h1234_0000);
        run_alu(ALU_ADD, 1'b0, 32'd1, 32'd2, 32'h0, 5'd0, 5'd0, 32'd0);

        run_branch(32'd9, 32'd9, 32'd3, 32'h100, 1'b1, 32'h110);
        run_branch(32'd9, 32'd8, 32'd3, 32'h100, 1'b0, 32'h110);

        // Link writes the return address to register 31.
        expect_retire(1'b1, 5'd31, 32'h208);
        issue_op(ALU_ADD, 1'b0, 32'h0, 32'h0, 32'h0, 32'h200, 5'd0, 1'b1, 1'b0, 1'b0,
                 1'b0, 1'b0, 1'b1, 5'd2, SIZE_WORD);
        go_idle();

        run_store(SIZE_WORD, 32'h40, 32'hdead_beef, 4'b1111, 32'hdead_beef);
        run_load(SIZE_WORD, 1'b0, 32'h40, 4'b1111, 5'd10, 32'hdead_beef);
        run_store(SIZE_HALF, 32'h46, 32'h0000_8001, 4'b1100, 32'h8001_0000);
        run_load(SIZE_HALF, 1'b0, 32'h46, 4'b1100, 5'd11, 32'hffff_8001);
        run_load(SIZE_HALF, 1'b1, 32'h46, 4'b1100, 5'd12, 32'h0000_8001);
        run_load(SIZE_BYTE, 1'b0, 32'h47, 4'b1000, 5'd13, 32'hffff_ff80);
        run_store(SIZE_BYTE, 32'h49, 32'h0000_0085, 4'b0010, 32'h0000_8500);
        run_load(SIZE_BYTE, 1'b0, 32'h49, 4'b0010, 5'd14, 32'hffff_ff85);
        run_load(SIZE_BYTE, 1'b1, 32'h49, 4'b0010, 5'd15, 32'h0000_0085);

        // Back-to-back mix under wait states.
        expect_retire(1'b1, 5'd16, 32'd30);
        issue_op(ALU_ADD, 1'b0, 32'd10, 32'd20, 32'h0, 32'h0, 5'd0, 1'b1, 1'b0, 1'b0,
                 1'b0, 1'b0, 1'b0, 5'd16, SIZE_WORD);
        expect_retire(1'b1, 5'd17, 32'hdead_beef);
        issue_op(ALU_ADD, 1'b1, 32'h40, 32'h0, 32'h0, 32'h0, 5'd0, 1'b1, 1'b1, 1'b0,
                 1'b0, 1'b0, 1'b0, 5'd17, SIZE_WORD);
        expect_retire(1'b1, 5'd18, 32'd1);
        issue_op(ALU_SUB, 1'b0, 32'd5, 32'd4, 32'h0, 32'h0, 5'd0, 1'b1, 1'b0, 1'b0,
                 1'b0, 1'b0, 1'b0, 5'd18, SIZE_WORD);
        expect_retire(1'b0, 5'd0, 32'h0);
        issue_op(ALU_ADD, 1'b1, 32'h80, 32'h1357_9bdf, 32'h0, 32'h0, 5'd0, 1'b0, 1'b0,
                 1'b1, 1'b0, 1'b0, 1'b0, 5'd0, SIZE_WORD);
        expect_retire(1'b1, 5'd19, 32'h1357_9bdf);
        issue_op(ALU_ADD, 1'b1, 32'h80, 32'h0, 32'h0, 32'h0, 5'd0, 1'b1, 1'b1, 1'b0,
                 1'b0, 1'b0, 1'b0, 5'd19, SIZE_WORD);
        expect_retire(1'b1, 5'd20, 32'h0000_00f0);
        issue_op(ALU_OR, 1'b0, 32'h0000_00a0, 32'h0000_0050, 32'h0, 32'h0, 5'd0, 1'b1,
                 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 5'd20, SIZE_WORD);
        go_idle();
        while (exp_we.size() > 0) begin
            @(negedge i_clock);
        end
        repeat (4) @(negedge i_clock);

        $display("Verification passed");
        $finish;
    end

endmodule

/* tb_wb_memory.sv */
module tb_wb_memory (
    input  logic        i_clock,
    input  logic        reset,
    input  logic        cyc,
    input  logic        stb,
    input  logic        we,
    input  logic [31:0] adr,
    input  logic [3:0]  sel,
    input  logic [31:0] dat_w,
    output logic [31:0] dat_r,
    output logic        ack
);

    logic [31:0] mem [0:255];
    logic [31:0] lfsr;
    logic [31:0] lfsr_next;
    logic [1:0]  draw;
    logic [1:0]  wait_cnt;
    logic [7:0]  index;

    // Taps 32, 22, 2, 1.
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    assign index     = adr[9:2];
    assign lfsr_next = lfsr_step(lfsr);
    assign draw      = {lfsr[0], lfsr_next[0]};

    initial begin
        for (int i = 0; i < 256; i++) begin
            mem[i] = 32'h5a00_0000 ^ (i * 32'h0101_0101);
        end
    end

    always @(posedge i_clock) begin
        if (reset) begin
            lfsr     <= 32'he7c6_2e64;
            ack      <= 1'b0;
            wait_cnt <= 2'd0;
            dat_r    <= '0;
        end else begin
            // Two bits per cycle for the wait count.
            lfsr <= lfsr_step(lfsr_next);
            if (ack) begin
                ack      <= 1'b0;
                wait_cnt <= draw;
            end else if (cyc && stb) begin
                if (wait_cnt == 2'd0) begin
                    ack   <= 1'b1;
                    dat_r <= mem[index];
                    if (we) begin
                        for (int b = 0; b < 4; b++) begin
                            if (sel[b]) begin
                                mem[index][8*b +: 8] <= dat_w[8*b +: 8];
                            end
                        end
                    end
                end else begin
                    wait_cnt <= wait_cnt - 2'd1;
                end
            end else begin
                wait_cnt <= draw;
            end
        end
    end

endmodule

/* mips_backend.sv */
`include "mips_params.svh"

module mips_backend
    import mips_ctrl_pkg::*, mips_data_pkg::*;
(
    input  logic                        i_clock,
    input  logic                        reset,
    // Issue side.
    input  logic                        issue_valid,
    input  alu_op_t                     alu_op,
    input  logic                        alu_src,
    input  word_t                       operand_a,
    input  word_t                       operand_b,
    input  word_t                       imm,
    input  word_t                       pc,
    input  logic [$clog2(`WORD_W)-1:0]  shamt,
    input  logic                        reg_write,
    input  logic                        mem_to_reg,
    input  logic                        mem_read,
    input  logic                        mem_write,
    input  logic                        branch,
    input  logic                        load_unsigned,
    input  logic                        r31_ctrl,
    input  reg_idx_t                    dest_reg,
    input  access_size_t                size,
    output logic                        issue_ready,
    output logic                        branch_taken,
    output word_t                       branch_target,
    // Write-back.
    output logic                        wb_valid,
    output logic                        wb_we,
    output reg_idx_t                    wb_reg,
    output word_t                       wb_data,
    // Wishbone data port.
    output logic                        wb_cyc,
    output logic                        wb_stb,
    output logic                        wb_write,
    output word_t                       wb_adr,
    output logic [`WORD_W/8-1:0]        wb_sel,
    output word_t                       wb_dat_w,
    input  word_t                       wb_dat_r,
    input  logic                        wb_ack
);

    logic       stall;
    logic       result_valid;
    logic       result_we;
    reg_idx_t   result_reg;
    word_t      result_data;

    ex_mem_if ex_side ();
    ex_mem_if mem_side ();

    assign issue_ready = ~stall;

    execute_stage execute_stage_i (
        .issue_valid   (issue_valid),
        .alu_op        (alu_op),
        .alu_src       (alu_src),
        .operand_a     (operand_a),
        .operand_b     (operand_b),
        .imm           (imm),
        .pc            (pc),
        .shamt         (shamt),
        .reg_write     (reg_write),
        .mem_to_reg    (mem_to_reg),
        .mem_read      (mem_read),
        .mem_write     (mem_write),
        .branch        (branch),
        .load_unsigned (load_unsigned),
        .r31_ctrl      (r31_ctrl),
        .dest_reg      (dest_reg),
        .size          (size),
        .ex_side       (ex_side.producer)
    );

    ex_mem_reg ex_mem_reg_i (
        .i_clock       (i_clock),
        .reset         (reset),
        .stall         (stall),
        .ex_side       (ex_side.consumer),
        .mem_side      (mem_side.producer),
        .branch_taken  (branch_taken),
        .branch_target (branch_target)
    );

    mem_access mem_access_i (
        .i_clock       (i_clock),
        .reset         (reset),
        .mem_side      (mem_side.consumer),
        .stall         (stall),
        .result_valid  (result_valid),
        .result_we     (result_we),
        .result_reg    (result_reg),
        .result_data   (result_data),
        .wb_cyc        (wb_cyc),
        .wb_stb        (wb_stb),
        .wb_we         (wb_write),
        .wb_adr        (wb_adr),
        .wb_sel        (wb_sel),
        .wb_dat_w      (wb_dat_w),
        .wb_dat_r      (wb_dat_r),
        .wb_ack        (wb_ack)
    );

    mem_wb_reg mem_wb_reg_i (
        .i_clock       (i_clock),
        .reset         (reset),
        .result_valid  (result_valid),
        .result_we     (result_we),
        .result_reg    (result_reg),
        .result_data   (result_data),
        .wb_valid      (wb_valid),
        .wb_we         (wb_we),
        .wb_reg        (wb_reg),
        .wb_data       (wb_data)
    );

endmodule

/* mem_wb_reg.sv */
module mem_wb_reg
    import mips_data_pkg::*;
(
    input  logic        i_clock,
    input  logic        reset,
    input  logic        result_valid,
    input  logic        result_we,
    input  reg_idx_t    result_reg,
    input  word_t       result_data,
    output logic        wb_valid,
    output logic        wb_we,
    output reg_idx_t    wb_reg,
    output word_t       wb_data
);

    always_ff @(posedge i_clock) begin
        if (reset) begin
            wb_valid <= 1'b0;
            wb_we    <= 1'b0;
        end else begin
            wb_valid <= result_valid;
            // Register zero is hardwired.
            wb_we    <= result_valid & result_we & (result_reg != '0);
        end
    end

    always_ff @(posedge i_clock) begin
        if (result_valid) begin
            wb_reg  <= result_reg;
            wb_data <= result_data;
        end
    end

endmodule

/* mem_access.sv */
`include "mips_params.svh"

module mem_access
    import mips_ctrl_pkg::*, mips_data_pkg::*;
(
    input  logic                    i_clock,
    input  logic                    reset,
    ex_mem_if.consumer              mem_side,
    output logic                    stall,
    output logic                    result_valid,
    output logic                    result_we,
    output reg_idx_t                result_reg,
    output word_t                   result_data,
    output logic                    wb_cyc,
    output logic                    wb_stb,
    output logic                    wb_we,
    output word_t                   wb_adr,
    output logic [`WORD_W/8-1:0]    wb_sel,
    output word_t                   wb_dat_w,
    input  word_t                   wb_dat_r,
    input  logic                    wb_ack
);

    logic           mem_req;
    logic           busy;
    logic           done;
    logic [1:0]     offset;
    mem_word_u      store_word;
    mem_word_u      load_word;
    logic [7:0]     load_byte;
    logic [15:0]    load_half;
    word_t          load_data;

    assign mem_req = mem_side.valid & (mem_side.mem_read | mem_side.mem_write);
    assign offset  = mem_side.alu_result[1:0];

    // ########################################
    // Wishbone cycle control
    // ########################################

    // Done hides an acked access still sitting in EX/MEM.
    always_ff @(posedge i_clock) begin
        if (reset) begin
            busy <= 1'b0;
            done <= 1'b0;
        end else begin
            busy <= mem_req & ~(wb_cyc & wb_ack);
            done <= wb_cyc & wb_ack;
        end
    end

    assign stall  = busy;
    assign wb_cyc = mem_req & ~done;
    assign wb_stb = wb_cyc;
    assign wb_we  = mem_side.mem_write;
    assign wb_adr = {mem_side.alu_result[`WORD_W-1:2], 2'b00};

    // ########################################
    // Lane steering
    // ########################################

    always_comb begin
        store_word.word = '0;
        case (mem_side.size)
            SIZE_BYTE: begin
                store_word.bytes[offset] = mem_side.data_b[7:0];
                wb_sel = 4'b0001 << offset;
            end
            SIZE_HALF: begin
                store_word.halves[offset[1]] = mem_side.data_b[15:0];
                wb_sel = offset[1] ? 4'b1100 : 4'b0011;
            end
            default: begin
                store_word.word = mem_side.data_b;
                wb_sel = 4'b1111;
            end
        endcase
    end

    assign wb_dat_w = store_word.word;

    assign load_word.word = wb_dat_r;
    assign load_byte      = load_word.bytes[offset];
    assign load_half      = load_word.halves[offset[1]];

    // Sign bit is dropped for unsigned loads.
    always_comb begin
        case (mem_side.size)
            SIZE_BYTE: load_data = {{24{load_byte[7] & ~mem_side.load_unsigned}}, load_byte};
            SIZE_HALF: load_data = {{16{load_half[15] & ~mem_side.load_unsigned}}, load_half};
            default:   load_data = load_word.word;
        endcase
    end

    assign result_valid = mem_req ? (wb_cyc & wb_ack) : mem_side.valid;
    assign result_we    = mem_side.reg_write & ~mem_side.mem_write;
    assign result_reg   = mem_side.selected_reg;
    assign result_data  = mem_side.mem_to_reg ? load_data : mem_side.alu_result;

    // Request held inside the cycle until ack.
    assert property (@(posedge i_clock) disable iff (reset)
        wb_stb && !wb_ack |=> wb_stb && wb_cyc && $stable({wb_adr, wb_sel, wb_we, wb_dat_w}));

    // Natural alignment from the issuer.
    assert property (@(posedge i_clock) disable iff (reset)
        mem_req |-> (mem_side.size != SIZE_HALF || !offset[0]) &&
                    (mem_side.size != SIZE_WORD || offset == 2'b00));

endmodule

/* ex_mem_reg.sv */
module ex_mem_reg
    import mips_data_pkg::*;
(
    input  logic        i_clock,
    input  logic        reset,
    input  logic        stall,
    ex_mem_if.consumer  ex_side,
    ex_mem_if.producer  mem_side,
    output logic        branch_taken,
    output word_t       branch_target
);

    // Control flags.
    always_ff @(negedge i_clock) begin
        if (reset) begin
            mem_side.valid         <= 1'b0;
            mem_side.reg_write     <= 1'b0;
            mem_side.mem_to_reg    <= 1'b0;
            mem_side.mem_read      <= 1'b0;
            mem_side.mem_write     <= 1'b0;
            mem_side.branch        <= 1'b0;
            mem_side.load_unsigned <= 1'b0;
            mem_side.r31_ctrl      <= 1'b0;
        end else if (!stall) begin
            mem_side.valid         <= ex_side.valid;
            mem_side.reg_write     <= ex_side.reg_write;
            mem_side.mem_to_reg    <= ex_side.mem_to_reg;
            mem_side.mem_read      <= ex_side.mem_read;
            mem_side.mem_write     <= ex_side.mem_write;
            mem_side.branch        <= ex_side.branch;
            mem_side.load_unsigned <= ex_side.load_unsigned;
            mem_side.r31_ctrl      <= ex_side.r31_ctrl;
        end
    end

    // Payload.
    always_ff @(negedge i_clock) begin
        if (!stall) begin
            mem_side.branch_addr  <= ex_side.branch_addr;
            mem_side.zero         <= ex_side.zero;
            mem_side.alu_result   <= ex_side.alu_result;
            mem_side.data_b       <= ex_side.data_b;
            mem_side.selected_reg <= ex_side.selected_reg;
            mem_side.size         <= ex_side.size;
            mem_side.pc           <= ex_side.pc;
        end
    end

    assign branch_taken  = mem_side.valid & mem_side.branch & mem_side.zero;
    assign branch_target = mem_side.branch_addr;

    // Bundle frozen for the whole memory access.
    assert property (@(negedge i_clock) disable iff (reset)
        stall |=> $stable({mem_side.valid, mem_side.reg_write, mem_side.mem_to_reg,
                           mem_side.mem_read, mem_side.mem_write, mem_side.branch,
                           mem_side.branch_addr, mem_side.zero, mem_side.alu_result,
                           mem_side.data_b, mem_side.selected_reg, mem_side.size,
                           mem_side.load_unsigned, mem_side.r31_ctrl, mem_side.pc}));

endmodule

/* execute_stage.sv */
`include "mips_params.svh"

module execute_stage
    import mips_ctrl_pkg::*, mips_data_pkg::*;
(
    input  logic                        issue_valid,
    input  alu_op_t                     alu_op,
    input  logic                        alu_src,
    input  word_t                       operand_a,
    input  word_t                       operand_b,
    input  word_t                       imm,
    input  word_t                       pc,
    input  logic [$clog2(`WORD_W)-1:0]  shamt,
    input  logic                        reg_write,
    input  logic                        mem_to_reg,
    input  logic                        mem_read,
    input  logic                        mem_write,
    input  logic                        branch,
    input  logic                        load_unsigned,
    input  logic                        r31_ctrl,
    input  reg_idx_t                    dest_reg,
    input  access_size_t                size,
    ex_mem_if.producer                  ex_side
);

    word_t alu_b;
    word_t alu_out;

    // Immediate replaces rt for I-type operations.
    assign alu_b = alu_src ? imm : operand_b;

    always_comb begin
        case (alu_op)
            ALU_ADD:  alu_out = operand_a + alu_b;
            ALU_SUB:  alu_out = operand_a - alu_b;
            ALU_AND:  alu_out = operand_a & alu_b;
            ALU_OR:   alu_out = operand_a | alu_b;
            ALU_XOR:  alu_out = operand_a ^ alu_b;
            ALU_NOR:  alu_out = ~(operand_a | alu_b);
            ALU_SLT:  alu_out = word_t'($signed(operand_a) < $signed(alu_b));
            ALU_SLTU: alu_out = word_t'(operand_a < alu_b);
            ALU_SLL:  alu_out = alu_b << shamt;
            ALU_SRL:  alu_out = alu_b >> shamt;
            ALU_SRA:  alu_out = word_t'($signed(alu_b) >>> shamt);
            ALU_LUI:  alu_out = {alu_b[`WORD_W/2-1:0], {(`WORD_W/2){1'b0}}};
            default:  alu_out = '0;
        endcase
    end

    assign ex_side.valid         = issue_valid;
    assign ex_side.reg_write     = reg_write;
    assign ex_side.mem_to_reg    = mem_to_reg;
    assign ex_side.mem_read      = mem_read;
    assign ex_side.mem_write     = mem_write;
    assign ex_side.branch        = branch;
    assign ex_side.zero          = (alu_out == '0);
    assign ex_side.branch_addr   = pc + word_t'(4) + (imm << 2);
    assign ex_side.data_b        = operand_b;
    assign ex_side.size          = size;
    assign ex_side.load_unsigned = load_unsigned;
    assign ex_side.r31_ctrl      = r31_ctrl;
    assign ex_side.pc            = pc;

    // Link ops return past the delay slot.
    assign ex_side.alu_result   = r31_ctrl ? pc + word_t'(8) : alu_out;
    assign ex_side.selected_reg = r31_ctrl ? reg_idx_t'(`LINK_REG) : dest_reg;

endmodule

/* ex_mem_if.sv */
interface ex_mem_if
    import mips_ctrl_pkg::*, mips_data_pkg::*;
();

    logic           valid;
    logic           reg_write;
    logic           mem_to_reg;
    logic           mem_read;
    logic           mem_write;
    logic           branch;
    word_t          branch_addr;
    logic           zero;
    word_t          alu_result;
    word_t          data_b;
    reg_idx_t       selected_reg;
    access_size_t   size;
    logic           load_unsigned;
    logic           r31_ctrl;
    word_t          pc;

    modport producer (
        output valid, reg_write, mem_to_reg, mem_read, mem_write,
        output branch, branch_addr, zero, alu_result, data_b,
        output selected_reg, size, load_unsigned, r31_ctrl, pc
    );

    modport consumer (
        input valid, reg_write, mem_to_reg, mem_read, mem_write,
        input branch, branch_addr, zero, alu_result, data_b,
        input selected_reg, size, load_unsigned, r31_ctrl, pc
    );

endinterface

/* mips_data_pkg.sv */
`include "mips_params.svh"

package mips_data_pkg;

    typedef logic [`WORD_W-1:0] word_t;

    typedef logic [`REG_W-1:0] reg_idx_t;

    // Memory word, whole or split into lanes.
    typedef union packed {
        word_t                          word;
        logic [`WORD_W/8-1:0][7:0]      bytes;
        logic [`WORD_W/16-1:0][15:0]    halves;
    } mem_word_u;

endpackage

/* mips_ctrl_pkg.sv */
package mips_ctrl_pkg;

    // ALU operations.
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_NOR  = 4'd5,
        ALU_SLT  = 4'd6,
        ALU_SLTU = 4'd7,
        ALU_SLL  = 4'd8,
        ALU_SRL  = 4'd9,
        ALU_SRA  = 4'd10,
        ALU_LUI  = 4'd11
    } alu_op_t;

    // Data memory access size.
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } access_size_t;

endpackage

/* mips_params.svh */
`ifndef MIPS_PARAMS_SVH
`define MIPS_PARAMS_SVH

// Data and address width.
`define WORD_W 32

// Register index width.
`define REG_W 5

// Return address register of link instructions.
`define LINK_REG 31

`endif
